// File: rtl/csee_config.svh
`ifndef CSEE_CONFIG_SVH
`define CSEE_CONFIG_SVH

// Positions evaluated in parallel each step
`define CSEE_LANES 8

// Steps per codeword giving 192 positions in all
`define CSEE_STEPS 24

// Correction limit of the decoder
`define CSEE_T 2

// x^8+x^4+x^3+x^2+1 without the x^8 term
`define GF_POLY_LOW 8'h1d

`endif

// File: rtl/gf_pkg.sv
`default_nettype none

`include "csee_config.svh"

package gf_pkg;

    typedef logic [7:0] gf_elem_t;

    // Shift and add with reduction by the field polynomial
    function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
        gf_elem_t acc;
        gf_elem_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? `GF_POLY_LOW : 8'h00);
        end
        return acc;
    endfunction

    // a^254 maps zero to zero
    function automatic gf_elem_t gf_inv(input gf_elem_t a);
        gf_elem_t sq;
        gf_elem_t acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic gf_elem_t gf_alpha_pow(input int unsigned n);
        logic [7:0] e;
        gf_elem_t   base;
        gf_elem_t   acc;
        e    = 8'(n % 255);
        base = 8'h02;
        acc  = 8'h01;
        for (int i = 0; i < 8; i++) begin
            if (e[i]) begin
                acc = gf_mul(acc, base);
            end
            base = gf_mul(base, base);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

// File: rtl/csee_pkg.sv
`default_nettype none

`include "csee_config.svh"

package csee_pkg;

    typedef enum logic [1:0] {
        IDLE,
        SEARCH,
        REPORT
    } csee_state_e;

    typedef struct packed {
        gf_pkg::gf_elem_t lambda0;
        gf_pkg::gf_elem_t lambda1;
        gf_pkg::gf_elem_t lambda2;
        gf_pkg::gf_elem_t omega0;
        gf_pkg::gf_elem_t omega1;
    } csee_poly_t;

    // Lane 0 sits in the low bits of flags and values
    typedef struct packed {
        logic                                     valid;
        logic [`CSEE_LANES-1:0]                   flags;
        gf_pkg::gf_elem_t [`CSEE_LANES-1:0]       values;
    } csee_step_t;

    typedef struct packed {
        logic       done;
        logic       fail;
        logic [7:0] count;
    } csee_result_t;

endpackage

`default_nettype wire

// File: rtl/csee_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module csee_fsm (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic last_step,
    output logic busy,
    output logic load,
    output logic advance,
    output logic report
);
    import csee_pkg::*;

    csee_state_e state;
    csee_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (start) state_next = SEARCH;
            SEARCH:  if (last_step) state_next = REPORT;
            REPORT:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Start is only taken while idle
    assign load    = (state == IDLE) && start;
    assign advance = (state == SEARCH);
    assign report  = (state == REPORT);
    assign busy    = advance || report;

endmodule

`default_nettype wire

// File: rtl/csee_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "csee_config.svh"

module csee_step_counter (
    input  logic clk,
    input  logic rstn,
    input  logic load,
    input  logic advance,
    output logic last_step
);

    logic [4:0] step_cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            step_cnt <= '0;
        end else if (load) begin
            step_cnt <= '0;
        end else if (advance) begin
            step_cnt <= step_cnt + 5'd1;
        end
    end

    assign last_step = (step_cnt == 5'(`CSEE_STEPS - 1));

endmodule

`default_nettype wire

// File: rtl/csee_root_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csee_config.svh"

module csee_root_regs (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  load,
    input  logic                  advance,
    input  csee_pkg::csee_poly_t  poly_in,
    output csee_pkg::csee_poly_t  poly_cur
);
    import gf_pkg::*;
    import csee_pkg::*;

    // One step moves every lane on by LANES positions
    localparam gf_elem_t ALPHA_STEP  = gf_alpha_pow(`CSEE_LANES);
    localparam gf_elem_t ALPHA_STEP2 = gf_alpha_pow(2 * `CSEE_LANES);

    csee_poly_t poly_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            poly_q <= '0;
        end else if (load) begin
            poly_q <= poly_in;
        end else if (advance) begin
            poly_q.lambda1 <= gf_mul(poly_q.lambda1, ALPHA_STEP);
            poly_q.lambda2 <= gf_mul(poly_q.lambda2, ALPHA_STEP2);
            poly_q.omega1  <= gf_mul(poly_q.omega1, ALPHA_STEP);
        end
    end

    assign poly_cur = poly_q;

endmodule

`default_nettype wire

// File: rtl/csee_lane.sv
`timescale 1ns/1ps
`default_nettype none

module csee_lane #(
    parameter int LANE = 0
) (
    input  csee_pkg::csee_poly_t poly_cur,
    output logic                 root,
    output gf_pkg::gf_elem_t     value
);
    import gf_pkg::*;

    // Each lane sits at x = alpha^(LANE+1) within the step
    localparam gf_elem_t ALPHA_X  = gf_alpha_pow(LANE + 1);
    localparam gf_elem_t ALPHA_X2 = gf_alpha_pow(2 * (LANE + 1));

    gf_elem_t l1_term;
    gf_elem_t l2_term;
    gf_elem_t o1_term;
    gf_elem_t err_val;

    assign l1_term = gf_mul(poly_cur.lambda1, ALPHA_X);
    assign l2_term = gf_mul(poly_cur.lambda2, ALPHA_X2);
    assign o1_term = gf_mul(poly_cur.omega1, ALPHA_X);

    assign root = ((poly_cur.lambda0 ^ l1_term ^ l2_term) == 8'h00);

    // Forney value is omega(x) over lambda1*x
    assign err_val = gf_mul(poly_cur.omega0 ^ o1_term, gf_inv(l1_term));
    assign value   = root ? err_val : 8'h00;

endmodule

`default_nettype wire

// File: rtl/csee_error_tally.sv
`timescale 1ns/1ps
`default_nettype none

`include "csee_config.svh"

module csee_error_tally (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   load,
    input  csee_pkg::csee_step_t   step,
    input  logic                   report,
    output csee_pkg::csee_result_t result
);

    logic [3:0] hits;
    logic [7:0] count_q;
    logic [7:0] count_next;
    logic       fail_q;

    always_comb begin
        hits = '0;
        for (int i = 0; i < `CSEE_LANES; i++) begin
            hits = hits + 4'(step.flags[i]);
        end
    end

    assign count_next = count_q + 8'(hits);

    ////////////////////////////////////////
    // Running count and verdict
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count_q <= '0;
            fail_q  <= 1'b0;
        end else if (load) begin
            count_q <= '0;
            fail_q  <= 1'b0;
        end else if (step.valid) begin
            count_q <= count_next;
            // Settles on the last step before the report cycle
            fail_q  <= (count_next == 8'd0) || (count_next > 8'(`CSEE_T));
        end
    end

    assign result.done  = report;
    assign result.fail  = fail_q;
    assign result.count = count_q;

endmodule

`default_nettype wire

// File: rtl/csee_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csee_config.svh"

module csee_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  csee_pkg::csee_poly_t   poly,
    output logic                   busy,
    output csee_pkg::csee_step_t   step,
    output csee_pkg::csee_result_t result
);
    import gf_pkg::*;
    import csee_pkg::*;

    logic                           load;
    logic                           advance;
    logic                           report;
    logic                           last_step;
    csee_poly_t                     poly_cur;
    logic [`CSEE_LANES-1:0]         lane_root;
    gf_elem_t [`CSEE_LANES-1:0]     lane_value;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    csee_fsm u_fsm (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .last_step (last_step),
        .busy      (busy),
        .load      (load),
        .advance   (advance),
        .report    (report)
    );

    csee_step_counter u_step_counter (
        .clk       (clk),
        .rstn      (rstn),
        .load      (load),
        .advance   (advance),
        .last_step (last_step)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    csee_root_regs u_root_regs (
        .clk      (clk),
        .rstn     (rstn),
        .load     (load),
        .advance  (advance),
        .poly_in  (poly),
        .poly_cur (poly_cur)
    );

    for (genvar i = 0; i < `CSEE_LANES; i++) begin : g_lane
        csee_lane #(.LANE(i)) u_lane (
            .poly_cur (poly_cur),
            .root     (lane_root[i]),
            .value    (lane_value[i])
        );
    end

    // Flags only count while a step is presented
    assign step.valid  = advance;
    assign step.flags  = lane_root & {`CSEE_LANES{advance}};
    assign step.values = lane_value;

    csee_error_tally u_error_tally (
        .clk    (clk),
        .rstn   (rstn),
        .load   (load),
        .step   (step),
        .report (report),
        .result (result)
    );

endmodule

`default_nettype wire

// File: tests/csee_tb_tasks.svh
`ifndef CSEE_TB_TASKS_SVH
`define CSEE_TB_TASKS_SVH

task automatic value_error(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    $display("error %s %s: expected %0h, actual %0h", name, what, exp, act);
    err_count++;
endtask

task automatic plain_failure(input string name, input string what);
    $display("%s: %s", name, what);
    err_count++;
endtask

task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
        $display("test %s passed", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, err_count - errs_before);
    end
endtask

task automatic start_search(input csee_poly_t p);
    @(posedge clk);
    #0.5;
    poly  = p;
    start = 1'b1;
endtask

// Compare one presented step with the model
task automatic check_step(input string name, input int k);
    logic [`CSEE_LANES-1:0] want;
    for (int i = 0; i < `CSEE_LANES; i++) begin
        want[i] = exp_flag[k * `CSEE_LANES + i];
    end
    if (step.flags !== want) begin
        value_error(name, $sformatf("step %0d flags", k), want, step.flags);
    end
    for (int i = 0; i < `CSEE_LANES; i++) begin
        if (step.values[i] !== exp_value[k * `CSEE_LANES + i]) begin
            value_error(name, $sformatf("position %0d value", k * `CSEE_LANES + i),
                        exp_value[k * `CSEE_LANES + i], step.values[i]);
        end
    end
    if (busy !== 1'b1) begin
        plain_failure(name, "busy was low during a valid step");
    end
endtask

// Runs until done and pulses start again at step poke_step if it is not negative
task automatic collect_search(input string name, input int poke_step);
    int   steps;
    int   waited;
    logic got_done;
    steps    = 0;
    waited   = 0;
    got_done = 1'b0;
    while (!got_done && waited < `CSEE_STEPS + 8) begin
        @(posedge clk);
        #0.5;
        start = (steps == poke_step);
        if (start) begin
            poly = random_poly();
        end
        @(negedge clk);
        waited++;
        if (waited == 1 && step.valid !== 1'b1) begin
            plain_failure(name, "first step did not follow the start");
        end
        if (step.valid === 1'b1) begin
            if (steps < `CSEE_STEPS) begin
                check_step(name, steps);
            end else begin
                plain_failure(name, "more valid steps than the search length");
            end
            steps++;
        end
        if (result.done === 1'b1) begin
            got_done = 1'b1;
            if (steps != `CSEE_STEPS) begin
                value_error(name, "valid step count", `CSEE_STEPS, steps);
            end
            if (result.count !== 8'(exp_count)) begin
                value_error(name, "count", exp_count, result.count);
            end
            if (result.fail !== exp_fail) begin
                value_error(name, "fail", exp_fail, result.fail);
            end
        end
    end
    start = 1'b0;
    if (!got_done) begin
        plain_failure(name, "result.done never came after the search");
    end
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic check_reset();
    int errs;
    errs = err_count;
    @(negedge clk);
    if (busy !== 1'b0) value_error("reset", "busy", 0, busy);
    if (step.valid !== 1'b0) value_error("reset", "step.valid", 0, step.valid);
    if (result.done !== 1'b0) value_error("reset", "result.done", 0, result.done);
    if (result.fail !== 1'b0) value_error("reset", "result.fail", 0, result.fail);
    if (result.count !== 8'd0) value_error("reset", "result.count", 0, result.count);
    close_test("reset", errs);
endtask

task automatic single_error_search();
    int         errs;
    int         a;
    csee_poly_t p;
    errs = err_count;
    a    = 1 + ($unsigned($random(seed)) % POSITIONS);
    p    = random_poly();
    p.lambda0 = ref_alpha_pow(a);
    p.lambda1 = 8'h01;
    p.lambda2 = 8'h00;
    build_expected(p);
    if (exp_count != 1 || !exp_flag[a - 1]) begin
        plain_failure("single_error", "model does not place the error at the chosen position");
    end
    start_search(p);
    collect_search("single_error", -1);
    close_test("single_error", errs);
endtask

task automatic two_error_search();
    int         errs;
    int         a;
    int         b;
    csee_poly_t p;
    errs = err_count;
    a    = 1 + ($unsigned($random(seed)) % POSITIONS);
    b    = 1 + ((a + $unsigned($random(seed)) % (POSITIONS - 1)) % POSITIONS);
    p    = random_poly();
    // (x + alpha^a)(x + alpha^b)
    p.lambda0 = ref_mul(ref_alpha_pow(a), ref_alpha_pow(b));
    p.lambda1 = ref_alpha_pow(a) ^ ref_alpha_pow(b);
    p.lambda2 = 8'h01;
    build_expected(p);
    if (exp_count != 2 || !exp_flag[a - 1] || !exp_flag[b - 1]) begin
        plain_failure("two_errors", "model does not place both errors at the chosen positions");
    end
    start_search(p);
    collect_search("two_errors", -1);
    close_test("two_errors", errs);
endtask

task automatic rootless_search();
    int         errs;
    csee_poly_t p;
    errs = err_count;
    p    = random_poly();
    p.lambda0 = 8'($random(seed)) | 8'h01;
    p.lambda1 = 8'h00;
    p.lambda2 = 8'h00;
    build_expected(p);
    start_search(p);
    collect_search("no_roots", -1);
    // Zero locator makes every position a root
    p.lambda0 = 8'h00;
    build_expected(p);
    start_search(p);
    collect_search("no_roots", -1);
    close_test("no_roots", errs);
endtask

task automatic busy_start_ignored();
    int errs;
    errs = err_count;
    start_search(random_poly());
    build_expected(poly);
    collect_search("busy_start", 10);
    start_search(random_poly());
    build_expected(poly);
    collect_search("busy_start", -1);
    repeat (4) begin
        @(negedge clk);
        if (step.valid !== 1'b0 || result.done !== 1'b0 || busy !== 1'b0) begin
            plain_failure("busy_start", "design was still active after the search ended");
        end
        if (result.count !== 8'(exp_count) || result.fail !== exp_fail) begin
            plain_failure("busy_start", "result did not hold after the search ended");
        end
    end
    close_test("busy_start", errs);
endtask

task automatic back_to_back_searches();
    int         errs;
    csee_poly_t p;
    errs = err_count;
    for (int n = 0; n < 4; n++) begin
        p = random_poly();
        build_expected(p);
        start_search(p);
        collect_search("back_to_back", -1);
    end
    close_test("back_to_back", errs);
endtask

`endif

// File: tests/csee_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csee_config.svh"

module csee_tb;
    import csee_pkg::*;

    localparam int POSITIONS    = `CSEE_LANES * `CSEE_STEPS;
    localparam int RESET_CYCLES = 4;
    // Ten searches of 24 steps plus start, report and slack, then reset and idle margin
    localparam int SEARCHES     = 10;
    localparam int MAX_CYCLES   = SEARCHES * 30 + 40;

    logic         clk = 1'b0;
    logic         rstn;
    logic         start;
    csee_poly_t   poly;
    logic         busy;
    csee_step_t   step;
    csee_result_t result;

    integer seed;
    int     cycle_cnt = 0;
    int     err_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    // Expected outcome of the current search
    logic       exp_flag [POSITIONS];
    logic [7:0] exp_value [POSITIONS];
    int         exp_count;
    logic       exp_fail;

    csee_top i_dut (
        .clk    (clk),
        .rstn   (rstn),
        .start  (start),
        .poly   (poly),
        .busy   (busy),
        .step   (step),
        .result (result)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Carry-less product folded back with x^8+x^4+x^3+x^2+1
    function automatic logic [7:0] ref_mul(input logic [7:0] a, input logic [7:0] b);
        logic [15:0] prod;
        prod = '0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                prod = prod ^ (16'(a) << i);
            end
        end
        for (int i = 15; i >= 8; i--) begin
            if (prod[i]) begin
                prod = prod ^ (16'h11d << (i - 8));
            end
        end
        return prod[7:0];
    endfunction

    // Exhaustive search that leaves zero at zero
    function automatic logic [7:0] ref_inv(input logic [7:0] a);
        logic [7:0] r;
        r = 8'h00;
        for (int b = 1; b < 256; b++) begin
            if (ref_mul(a, 8'(b)) == 8'h01) begin
                r = 8'(b);
            end
        end
        return r;
    endfunction

    function automatic logic [7:0] ref_alpha_pow(input int n);
        logic [7:0] r;
        r = 8'h01;
        for (int i = 0; i < n % 255; i++) begin
            r = ref_mul(r, 8'h02);
        end
        return r;
    endfunction

    function automatic csee_poly_t random_poly();
        csee_poly_t p;
        p = {8'($random(seed)), 32'($random(seed))};
        return p;
    endfunction

    task automatic build_expected(input csee_poly_t p);
        logic [7:0] x;
        logic [7:0] loc;
        logic [7:0] num;
        exp_count = 0;
        for (int i = 0; i < POSITIONS; i++) begin
            x   = ref_alpha_pow(i + 1);
            loc = p.lambda0 ^ ref_mul(p.lambda1, x) ^ ref_mul(p.lambda2, ref_mul(x, x));
            exp_flag[i]  = (loc == 8'h00);
            exp_value[i] = 8'h00;
            if (exp_flag[i]) begin
                num          = p.omega0 ^ ref_mul(p.omega1, x);
                exp_value[i] = ref_mul(num, ref_inv(ref_mul(p.lambda1, x)));
                exp_count++;
            end
        end
        exp_fail = (exp_count == 0) || (exp_count > `CSEE_T);
    endtask

    `include "csee_tb_tasks.svh"

    initial begin
        seed  = 32'h2262;
        rstn  = 1'b0;
        start = 1'b0;
        poly  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rstn = 1'b1;

        check_reset();
        single_error_search();
        two_error_search();
        rootless_search();
        busy_start_ignored();
        back_to_back_searches();

        $display("tests run %0d, tests failing %0d, errors %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: csee.f
+incdir+rtl
+incdir+tests
rtl/gf_pkg.sv
rtl/csee_pkg.sv
rtl/csee_fsm.sv
rtl/csee_step_counter.sv
rtl/csee_root_regs.sv
rtl/csee_lane.sv
rtl/csee_error_tally.sv
rtl/csee_top.sv
tests/csee_tb.sv

// File: Bender.yml
package:
  name: csee

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gf_pkg.sv
      - rtl/csee_pkg.sv
      - rtl/csee_fsm.sv
      - rtl/csee_step_counter.sv
      - rtl/csee_root_regs.sv
      - rtl/csee_lane.sv
      - rtl/csee_error_tally.sv
      - rtl/csee_top.sv
  - target: test
    include_dirs:
      - rtl
      - tests
    files:
      - tests/csee_tb.sv
